// ==== hw/card_bus_pkg.sv ====
package card_bus_pkg;

    // Host command codes
    typedef enum logic [1:0] {
        CMD_WRITE4 = 2'd0, // One byte per board, same register address
        CMD_READ4  = 2'd1,
        CMD_TEST   = 2'd2  // Status byte through the test-address strobe
    } cmd_type_t;

    // One read byte on its way from the sequencer to the framer
    typedef struct packed {
        logic [7:0] data;
        logic       last; // Byte from the final board slot
    } resp_entry_t;

    // Slots per command, fixed by the 32-bit command word
    localparam int BOARD_COUNT = 4;

    // Address valid to strobe, and minimum strobe width
    localparam int SETUP_NS = 750;

    // Idle gap ahead of every address phase
    localparam int PRE_DELAY_CYCLES = 2;

endpackage

// ==== hw/card_bus_sequencer.sv ====
`timescale 1ns/1ps

module card_bus_sequencer #(
    parameter int CLOCK_FREQUENCY = 10_000_000 // Hz
) (
    input  logic                      clock,
    input  logic                      rst,

    // Host command
    input  logic                      cmd_valid,
    input  card_bus_pkg::cmd_type_t   cmd_type,
    input  logic [2:0]                cmd_addr,
    input  logic [31:0]               cmd_data,
    output logic                      busy,
    output logic                      cmd_done,

    // Rack bus
    output logic [3:0]                board_select, // One-hot slot select
    output logic [2:0]                bus_addr,
    output logic                      test_address,
    output logic                      rd,
    output logic                      wr,
    output logic [7:0]                data_out,
    input  logic [7:0]                data_in,
    output logic                      data_dir,     // High while we drive data

    // Response queue
    input  logic                      full,
    output logic                      push,
    output card_bus_pkg::resp_entry_t push_entry
);
    import card_bus_pkg::*;

    // Setup time in clocks, rounded up
    localparam longint SETUP_PRODUCT = longint'(SETUP_NS) * longint'(CLOCK_FREQUENCY);
    localparam int     SETUP_RAW     = int'((SETUP_PRODUCT + 999_999_999) / 1_000_000_000);
    localparam int     S_CYCLES      = (SETUP_RAW < 1) ? 1 : SETUP_RAW;

    localparam int WAIT_MAX = (S_CYCLES > PRE_DELAY_CYCLES) ? S_CYCLES : PRE_DELAY_CYCLES;
    localparam int WAIT_W   = $clog2(WAIT_MAX + 1);
    localparam int IDX_W    = $clog2(BOARD_COUNT);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRE_DELAY,
        ST_ADDR_SETUP,   // Address valid, counting setup time
        ST_STROBE,
        ST_DATA_RELEASE,
        ST_PUSH,
        ST_RELEASE       // Drop the address, then next slot or done
    } state_t;

    state_t            state;
    logic [WAIT_W-1:0] wait_cnt;
    logic [IDX_W-1:0]  board_idx;

    cmd_type_t         cmd_type_q;
    logic [2:0]        cmd_addr_q;
    logic [31:0]       cmd_data_q;
    logic [7:0]        rd_byte;

    logic              accept;
    logic              wait_done;
    logic              is_write;
    logic              is_test;
    logic              last_board;

    assign accept     = (state == ST_IDLE) && cmd_valid; // Strobes while busy are dropped
    assign wait_done  = (wait_cnt == '0);
    assign is_write   = (cmd_type_q == CMD_WRITE4);
    assign is_test    = (cmd_type_q == CMD_TEST);
    assign last_board = (board_idx == IDX_W'(BOARD_COUNT - 1));

    // Held in ST_PUSH until the queue has room
    assign push       = (state == ST_PUSH) && !full;
    assign push_entry = '{data: rd_byte, last: last_board};

    // Command latch, bus payload and sampled read byte
    always_ff @(posedge clock) begin
        if (accept) begin
            cmd_type_q <= cmd_type;
            cmd_addr_q <= cmd_addr;
            cmd_data_q <= cmd_data;
        end
        if (state == ST_PRE_DELAY && wait_done) begin
            bus_addr <= cmd_addr_q;
            data_out <= cmd_data_q[board_idx*8 +: 8]; // Byte n goes to board n
        end
        // Last rd cycle
        if (state == ST_STROBE && wait_done && !is_write) begin
            rd_byte <= data_in;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state        <= ST_IDLE;
            wait_cnt     <= '0;
            board_idx    <= '0;
            busy         <= 1'b0;
            cmd_done     <= 1'b0;
            board_select <= '0;
            test_address <= 1'b0;
            rd           <= 1'b0;
            wr           <= 1'b0;
            data_dir     <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            if (!wait_done) begin
                wait_cnt <= wait_cnt - 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        busy      <= 1'b1;
                        board_idx <= '0;
                        wait_cnt  <= WAIT_W'(PRE_DELAY_CYCLES - 1);
                        state     <= ST_PRE_DELAY;
                    end
                end
                ST_PRE_DELAY: begin
                    if (wait_done) begin
                        board_select <= 4'b0001 << board_idx;
                        test_address <= is_test;
                        data_dir     <= is_write; // Data goes out with the address
                        wait_cnt     <= WAIT_W'(S_CYCLES - 1);
                        state        <= ST_ADDR_SETUP;
                    end
                end
                ST_ADDR_SETUP: begin
                    if (wait_done) begin
                        wr       <= is_write;
                        rd       <= !is_write;
                        wait_cnt <= WAIT_W'(S_CYCLES - 1);
                        state    <= ST_STROBE;
                    end
                end
                ST_STROBE: begin
                    if (wait_done) begin
                        rd    <= 1'b0;
                        wr    <= 1'b0;
                        state <= is_write ? ST_DATA_RELEASE : ST_PUSH;
                    end
                end
                ST_DATA_RELEASE: begin
                    data_dir <= 1'b0; // One cycle of hold after wr falls
                    state    <= ST_RELEASE;
                end
                ST_PUSH: begin
                    if (!full) begin
                        state <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    board_select <= '0;
                    test_address <= 1'b0;
                    if (last_board) begin
                        cmd_done <= 1'b1;
                        busy     <= 1'b0;
                        state    <= ST_IDLE;
                    end else begin
                        board_idx <= board_idx + 1'b1;
                        wait_cnt  <= WAIT_W'(PRE_DELAY_CYCLES - 1);
                        state     <= ST_PRE_DELAY;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Boards see one strobe at a time, and only with a single slot selected
    assert property (@(posedge clock) disable iff (rst)
        (rd || wr) |-> !(rd && wr) && $onehot(board_select))
        else $error("strobe without a single board selected, or rd and wr together");

    // Queue back-pressure must hold the byte
    assert property (@(posedge clock) disable iff (rst)
        (state == ST_PUSH && full) |=> (state == ST_PUSH) && $stable(push_entry))
        else $error("read byte not held while the response queue was full");

endmodule

// ==== hw/response_queue.sv ====
`timescale 1ns/1ps

module response_queue #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 8
) (
    input  logic clock,
    input  logic rst,
    input  logic push,
    input  T     push_entry,
    input  logic pop,
    output T     pop_entry,  // Head entry, valid while not empty
    output logic full,
    output logic empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wraps at DEPTH, so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign pop_entry = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (rst) pop |-> !empty)
        else $error("pop from an empty response queue");

    assert property (@(posedge clock) disable iff (rst) push |-> !full)
        else $error("push into a full response queue");

endmodule

// ==== hw/response_framer.sv ====
`timescale 1ns/1ps

module response_framer (
    input  logic                      clock,
    input  logic                      rst,

    // Response queue head
    input  logic                      empty,
    input  card_bus_pkg::resp_entry_t pop_entry,
    output logic                      pop,

    // Host response
    output logic                      resp_valid,
    output logic [31:0]               resp_data,  // Byte n from board n
    output logic [2:0]                resp_count
);
    import card_bus_pkg::*;

    localparam int IDX_W = $clog2(BOARD_COUNT + 1);

    logic [IDX_W-1:0] idx_q;     // Next byte position
    logic [31:0]      asm_word;  // Bytes gathered so far
    logic [31:0]      next_word;

    // Drain whenever something is waiting
    assign pop = !empty;

    always_comb begin
        next_word = asm_word;
        if (idx_q < IDX_W'(BOARD_COUNT)) begin
            next_word[idx_q*8 +: 8] = pop_entry.data;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            idx_q      <= '0;
            resp_valid <= 1'b0;
            resp_count <= '0;
        end else begin
            resp_valid <= 1'b0;
            if (pop) begin
                if (pop_entry.last) begin
                    resp_valid <= 1'b1;
                    resp_count <= 3'(idx_q + 1'b1);
                    idx_q      <= '0;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    // Word assembly and the published response
    always_ff @(posedge clock) begin
        if (pop) begin
            if (pop_entry.last) begin
                resp_data <= next_word;
                asm_word  <= '0;
            end else begin
                asm_word <= next_word;
            end
        end
    end

    // Sequencer flags last on the final slot, so a byte always has a place
    assert property (@(posedge clock) disable iff (rst) pop |-> idx_q < IDX_W'(BOARD_COUNT))
        else $error("response byte index past BOARD_COUNT");

endmodule

// ==== hw/card_bus_top.sv ====
`timescale 1ns/1ps

module card_bus_top #(
    parameter int CLOCK_FREQUENCY = 10_000_000, // Hz, sets bus timing
    parameter int RESP_DEPTH      = 8
) (
    input  logic                    clock,
    input  logic                    rst,

    // Host side
    input  logic                    cmd_valid,
    input  card_bus_pkg::cmd_type_t cmd_type,
    input  logic [2:0]              cmd_addr,
    input  logic [31:0]             cmd_data,
    output logic                    busy,
    output logic                    cmd_done,
    output logic                    resp_valid,
    output logic [31:0]             resp_data,
    output logic [2:0]              resp_count,

    // Rack side
    output logic [3:0]              board_select,
    output logic [2:0]              bus_addr,
    output logic                    test_address,
    output logic                    rd,
    output logic                    wr,
    output logic [7:0]              data_out,
    input  logic [7:0]              data_in,
    output logic                    data_dir
);
    import card_bus_pkg::*;

    // Read bytes on their way to the framer
    logic        push;
    logic        full;
    logic        pop;
    logic        empty;
    resp_entry_t push_entry;
    resp_entry_t pop_entry;

    card_bus_sequencer #(
        .CLOCK_FREQUENCY (CLOCK_FREQUENCY)
    ) u_sequencer (
        .clock        (clock),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_type     (cmd_type),
        .cmd_addr     (cmd_addr),
        .cmd_data     (cmd_data),
        .busy         (busy),
        .cmd_done     (cmd_done),
        .board_select (board_select),
        .bus_addr     (bus_addr),
        .test_address (test_address),
        .rd           (rd),
        .wr           (wr),
        .data_out     (data_out),
        .data_in      (data_in),
        .data_dir     (data_dir),
        .full         (full),
        .push         (push),
        .push_entry   (push_entry)
    );

    response_queue #(
        .T     (resp_entry_t),
        .DEPTH (RESP_DEPTH)
    ) u_queue (
        .clock      (clock),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .pop_entry  (pop_entry),
        .full       (full),
        .empty      (empty)
    );

    response_framer u_framer (
        .clock      (clock),
        .rst        (rst),
        .empty      (empty),
        .pop_entry  (pop_entry),
        .pop        (pop),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_count (resp_count)
    );

endmodule

// ==== verif/card_rack_model.sv ====
`timescale 1ns/1ps

module card_rack_model (
    input  logic [3:0] board_select,
    input  logic [2:0] bus_addr,
    input  logic       test_address,
    input  logic       rd,
    input  logic       wr,
    input  logic [7:0] data_out,
    input  logic       data_dir,
    output logic [7:0] data_in,
    output logic       timing_fault
);
    import card_bus_pkg::*;

    logic [7:0] regs [BOARD_COUNT][8]; // Eight registers per board
    logic [3:0] sel_q;
    logic [2:0] addr_q;
    logic       test_q;
    logic       rd_q;
    logic       wr_q;
    realtime    addr_time;
    realtime    rd_rise;
    realtime    wr_rise;
    realtime    now;

    // Slot number of a one-hot select, -1 when none or several
    function automatic int slot_of(input logic [3:0] sel);
        int id;
        id = -1;
        for (int i = 0; i < BOARD_COUNT; i++) begin
            if (sel[i]) begin
                id = (id == -1) ? i : -2;
            end
        end
        return (id < 0) ? -1 : id;
    endfunction

    function automatic void flag_violation(input string what);
        $display("Bus timing violation at %0t ns: %s", $realtime, what);
        timing_fault = 1'b1;
    endfunction

    initial begin
        timing_fault = 1'b0;
        {sel_q, addr_q, test_q, rd_q, wr_q} = '0;
        addr_time = 0.0;
        rd_rise   = 0.0;
        wr_rise   = 0.0;
        for (int b = 0; b < BOARD_COUNT; b++) begin
            for (int a = 0; a < 8; a++) begin
                regs[b][a] = 8'(b * 8 + a) ^ 8'h5c; // Distinct per board and register
            end
        end
    end

    // Status byte on the test strobe, else the addressed register
    always_comb begin
        data_in = 8'h00;
        if (rd && slot_of(board_select) >= 0) begin
            if (test_address) begin
                data_in = 8'ha0 + 8'(slot_of(board_select));
            end else begin
                data_in = regs[slot_of(board_select)][bus_addr];
            end
        end
    end

    // Bus watcher and write capture in one process
    always @(board_select or bus_addr or test_address or rd or wr) begin
        now = $realtime;
        if (board_select != sel_q || bus_addr != addr_q || test_address != test_q) begin
            if (rd || wr) flag_violation("address changed while a strobe was high");
            addr_time = now;
        end
        if (rd && wr) flag_violation("rd and wr high at the same time");
        if (rd && !rd_q) begin
            rd_rise = now;
            if (now - addr_time < real'(SETUP_NS)) flag_violation("rd rose before setup time");
        end
        if (wr && !wr_q) begin
            wr_rise = now;
            if (now - addr_time < real'(SETUP_NS)) flag_violation("wr rose before setup time");
        end
        if (!rd && rd_q && now - rd_rise < real'(SETUP_NS)) flag_violation("rd strobe too short");
        if (!wr && wr_q) begin
            if (now - wr_rise < real'(SETUP_NS)) flag_violation("wr strobe too short");
            if (data_dir && slot_of(board_select) >= 0) begin
                regs[slot_of(board_select)][bus_addr] = data_out; // Store on falling wr
            end
        end
        {sel_q, addr_q, test_q, rd_q, wr_q} = {board_select, bus_addr, test_address, rd, wr};
    end

endmodule

// ==== verif/tb_card_bus.sv ====
`timescale 1ns/1ps

module tb_card_bus;
    import card_bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic        clock;
    logic        rst;
    logic        cmd_valid;
    cmd_type_t   cmd_type;
    logic [2:0]  cmd_addr;
    logic [31:0] cmd_data;
    logic        busy;
    logic        cmd_done;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic [2:0]  resp_count;
    logic [3:0]  board_select;
    logic [2:0]  bus_addr;
    logic        test_address;
    logic        rd;
    logic        wr;
    logic [7:0]  data_out;
    logic [7:0]  data_in;
    logic        data_dir;
    logic        timing_fault;

    logic [7:0]  shadow [BOARD_COUNT][8]; // Expected rack contents
    logic [31:0] exp_words [$];
    string       exp_names [$];
    logic [31:0] last_resp;
    int          sent_count = 0;
    int          done_count = 0;
    int          resp_total = 0;

    card_bus_top #(.CLOCK_FREQUENCY(10_000_000)) u_dut (.*);

    card_rack_model u_rack (
        .board_select (board_select),
        .bus_addr     (bus_addr),
        .test_address (test_address),
        .rd           (rd),
        .wr           (wr),
        .data_out     (data_out),
        .data_dir     (data_dir),
        .data_in      (data_in),
        .timing_fault (timing_fault)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("Mismatch in %s: expected %h actual %h",
                                      name, expected, actual));
        end
    endtask

    // Response word a command should return; writes update the shadow
    function automatic logic [31:0] expected_response(input cmd_type_t cmd, input logic [2:0] addr,
                                                      input logic [31:0] data);
        logic [31:0] word;
        word = '0;
        for (int n = 0; n < BOARD_COUNT; n++) begin
            case (cmd)
                CMD_WRITE4: shadow[n][addr] = data[n*8 +: 8];
                CMD_READ4:  word[n*8 +: 8] = shadow[n][addr];
                default:    word[n*8 +: 8] = 8'ha0 + 8'(n); // Board status byte
            endcase
        end
        return word;
    endfunction

    task automatic wait_for_idle(input string name);
        int cycles;
        cycles = 0;
        while (done_count != sent_count || exp_words.size() != 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_error($sformatf("Timeout waiting for %s", name));
            end
        end
    endtask

    task automatic run_command(input cmd_type_t cmd, input logic [2:0] addr,
                               input logic [31:0] data, input string name);
        logic [31:0] want;
        wait_for_idle(name);
        want = expected_response(cmd, addr, data);
        if (cmd != CMD_WRITE4) begin
            exp_words.push_back(want);
            exp_names.push_back(name);
        end
        sent_count++;
        @(negedge clock);
        cmd_valid = 1'b1;
        cmd_type  = cmd;
        cmd_addr  = addr;
        cmd_data  = data;
        @(negedge clock);
        cmd_valid = 1'b0;
    endtask

    // Counts completions and compares every response
    initial begin : compare_responses
        int          idle;
        logic [31:0] want;
        string       name;
        idle = 0;
        while (rst !== 1'b0) begin
            @(negedge clock);
            idle++;
            if (idle > TIMEOUT_CYCLES) stop_with_error("Reset was never released");
        end
        forever begin
            idle = 0;
            do begin
                @(negedge clock);
                idle++;
                if (idle > TIMEOUT_CYCLES) begin
                    stop_with_error("No response or completion from the DUT");
                end
            end while (!(resp_valid || cmd_done));
            if (cmd_done) done_count++;
            if (resp_valid) begin
                resp_total++;
                last_resp = resp_data;
                if (exp_words.size() == 0) begin
                    stop_with_error("Response arrived with no read or test outstanding");
                end else begin
                    want = exp_words.pop_front();
                    name = exp_names.pop_front();
                    check(name, want, resp_data);
                    check({name, " count"}, 32'(BOARD_COUNT), 32'(resp_count));
                end
            end
        end
    end

    always @(negedge clock) begin
        if (timing_fault) stop_with_error("Rack model reported a bus timing violation");
    end

    initial begin
        int resp_before;
        int done_before;
        void'($urandom(32'hcee19cab));
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_type  = CMD_WRITE4;
        cmd_addr  = '0;
        cmd_data  = '0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        check("reset outputs", 32'h0,
              32'({busy, cmd_done, resp_valid, rd, wr, test_address, board_select, data_dir}));
        rst = 1'b0;

        // Known contents in every register before any read
        for (int a = 0; a < 8; a++) begin
            run_command(CMD_WRITE4, 3'(a), $urandom, "preload");
        end
        wait_for_idle("preload");

        resp_before = resp_total;
        run_command(CMD_WRITE4, 3'd5, 32'h5a3c96e1, "write_read");
        wait_for_idle("write_read");
        check("write_read no response", 32'(resp_before), 32'(resp_total));
        run_command(CMD_READ4, 3'd5, 32'h0, "write_read");
        wait_for_idle("write_read");
        check("write_read data", 32'h5a3c96e1, last_resp);

        run_command(CMD_TEST, 3'd0, 32'h0, "test_status");
        wait_for_idle("test_status");

        // Second strobe lands while the first write is running
        done_before = done_count;
        run_command(CMD_WRITE4, 3'd2, 32'h11223344, "busy_ignore");
        resp_before = 0;
        while (!busy) begin
            @(negedge clock);
            resp_before++;
            if (resp_before > TIMEOUT_CYCLES) stop_with_error("busy never rose after a command");
        end
        cmd_valid = 1'b1;
        cmd_type  = CMD_WRITE4;
        cmd_addr  = 3'd2;
        cmd_data  = 32'hdeadbeef;
        @(negedge clock);
        cmd_valid = 1'b0;
        wait_for_idle("busy_ignore");
        repeat (200) @(negedge clock);
        check("busy_ignore done count", 32'(done_before + 1), 32'(done_count));
        run_command(CMD_READ4, 3'd2, 32'h0, "busy_ignore");
        wait_for_idle("busy_ignore");
        check("busy_ignore data", 32'h11223344, last_resp);

        for (int i = 0; i < 40; i++) begin
            run_command(cmd_type_t'($urandom_range(0, 1)), 3'($urandom_range(0, 7)), $urandom,
                        "random");
        end
        wait_for_idle("random");
        check("random busy", 32'h0, 32'(busy));

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== list.f ====
hw/card_bus_pkg.sv
hw/card_bus_sequencer.sv
hw/response_queue.sv
hw/response_framer.sv
hw/card_bus_top.sv
verif/card_rack_model.sv
verif/tb_card_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_card_bus -f list.f

status=0
output=$(./obj_dir/Vtb_card_bus 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q '^=== PASS ===$'; then
    echo "Simulation passed (exit status $status)"
else
    echo "Simulation failed (exit status $status)"
    exit 1
fi
